//--- design/datapathPkg.sv
// datapath package holding the control word, field widths and ALU and branch encodings
package datapathPkg;

    // bus and register sizes
    localparam int WORD_WIDTH = 32;
    localparam int REG_INDEX_WIDTH = 4;

    // instruction field positions
    localparam int OPCODE_LSB = 27;
    localparam int OPCODE_WIDTH = 5;
    localparam int RA_LSB = 23;
    localparam int RB_LSB = 19;
    localparam int RC_LSB = 15;
    localparam int CONST_WIDTH = 19;
    // condition sits in the low bits of the Rb field
    localparam int COND_WIDTH = 2;

    typedef enum logic [4:0] {
        aluAdd = 5'd3,
        aluSub = 5'd4,
        aluAnd = 5'd5,
        aluOr  = 5'd6,
        aluNeg = 5'd7,
        aluNot = 5'd8,
        aluShl = 5'd9,
        aluShr = 5'd10
    } aluOp_t;

    typedef enum logic [1:0] {
        brzr = 2'd0,
        brnz = 2'd1,
        brpl = 2'd2,
        brmi = 2'd3
    } condCode_t;

    // one step worth of strobes
    typedef struct packed {
        // bus sources
        logic   pcOut;
        logic   zHighOut;
        logic   zLowOut;
        logic   mdrOut;
        logic   hiOut;
        logic   loOut;
        logic   inPortOut;
        logic   cOut;
        logic   rOut;
        // bus sinks
        logic   marIn;
        logic   pcIn;
        logic   mdrIn;
        logic   irIn;
        logic   yIn;
        logic   zHighIn;
        logic   zLowIn;
        logic   hiIn;
        logic   loIn;
        logic   rIn;
        logic   conIn;
        logic   outPortIn;
        // misc
        logic   branchLoad;
        logic   incPc;
        logic   read;
        logic   write;
        logic   gra;
        logic   grb;
        logic   grc;
        logic   baOut;
        aluOp_t aluOp;
    } controlWord;

endpackage

//--- design/registerFile.sv
// general register file with sixteen words selected through the IR register fields
`timescale 1ns/10ps

module registerFile (
    input  logic                                clock,
    input  logic                                arstN,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  bus,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  ir,
    input  datapathPkg::controlWord             control,
    output logic [datapathPkg::WORD_WIDTH-1:0]  regData
);
    import datapathPkg::*;

    localparam int REG_COUNT = 1 << REG_INDEX_WIDTH;

    logic [WORD_WIDTH-1:0]      regs [0:REG_COUNT-1];
    logic [REG_INDEX_WIDTH-1:0] select;
    logic                       forceZero;

    // register select from Ra, Rb or Rc
    always_comb begin
        select = '0;
        if (control.gra) begin
            select = ir[RA_LSB +: REG_INDEX_WIDTH];
        end else if (control.grb) begin
            select = ir[RB_LSB +: REG_INDEX_WIDTH];
        end else if (control.grc) begin
            select = ir[RC_LSB +: REG_INDEX_WIDTH];
        end
    end

    // base address reads R0 as zero
    assign forceZero = control.baOut && (select == '0);
    assign regData = forceZero ? '0 : regs[select];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (control.rIn) begin
            regs[select] <= bus;
        end
    end

endmodule

//--- design/specialRegisters.sv
// special registers PC, IR, HI, LO and the in and out ports on the shared bus
`timescale 1ns/10ps

module specialRegisters (
    input  logic                                clock,
    input  logic                                arstN,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  bus,
    input  datapathPkg::controlWord             control,
    input  logic                                con,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  inPortData,
    output logic [datapathPkg::WORD_WIDTH-1:0]  pc,
    output logic [datapathPkg::WORD_WIDTH-1:0]  ir,
    output logic [datapathPkg::WORD_WIDTH-1:0]  hi,
    output logic [datapathPkg::WORD_WIDTH-1:0]  lo,
    output logic [datapathPkg::WORD_WIDTH-1:0]  inPortValue,
    output logic [datapathPkg::WORD_WIDTH-1:0]  outPortData
);
    import datapathPkg::*;

    logic pcLoad;

    // branch target only taken when CON is set
    assign pcLoad = control.pcIn || (control.branchLoad && con);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            ir <= '0;
            hi <= '0;
            lo <= '0;
            outPortData <= '0;
        end else begin
            if (pcLoad) begin
                pc <= bus;
            end
            if (control.irIn) begin
                ir <= bus;
            end
            if (control.hiIn) begin
                hi <= bus;
            end
            if (control.loIn) begin
                lo <= bus;
            end
            if (control.outPortIn) begin
                outPortData <= bus;
            end
        end
    end

    // in port latch follows the pins every cycle
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            inPortValue <= {WORD_WIDTH{1'b0}};
        end else begin
            inPortValue <= inPortData;
        end
    end

endmodule

//--- design/aluUnit.sv
// ALU with the Y operand register and the Z high and low result registers
`timescale 1ns/10ps

module aluUnit (
    input  logic                                clock,
    input  logic                                arstN,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  bus,
    input  datapathPkg::controlWord             control,
    output logic [datapathPkg::WORD_WIDTH-1:0]  zHigh,
    output logic [datapathPkg::WORD_WIDTH-1:0]  zLow
);
    import datapathPkg::*;

    localparam int SHIFT_WIDTH = $clog2(WORD_WIDTH);

    logic [WORD_WIDTH-1:0] yReg;
    logic [WORD_WIDTH-1:0] operandA;
    aluOp_t                opSelect;
    logic [WORD_WIDTH:0]   sum;
    logic [WORD_WIDTH-1:0] resultHigh;
    logic [WORD_WIDTH-1:0] resultLow;

    // PC increment reuses the adder with a constant one
    assign operandA = control.incPc ? WORD_WIDTH'(1) : yReg;
    assign opSelect = control.incPc ? aluAdd : control.aluOp;
    assign sum = {1'b0, operandA} + {1'b0, bus};

    always_comb begin
        resultHigh = '0;
        case (opSelect)
            aluAdd: begin
                resultLow = sum[WORD_WIDTH-1:0];
                resultHigh = {{(WORD_WIDTH-1){1'b0}}, sum[WORD_WIDTH]};
            end
            aluSub: begin
                resultLow = operandA - bus;
                resultHigh = {WORD_WIDTH{resultLow[WORD_WIDTH-1]}};
            end
            aluAnd: resultLow = operandA & bus;
            aluOr:  resultLow = operandA | bus;
            aluNeg: resultLow = -bus;
            aluNot: resultLow = ~bus;
            aluShl: resultLow = operandA << bus[SHIFT_WIDTH-1:0];
            aluShr: resultLow = operandA >> bus[SHIFT_WIDTH-1:0];
            // unknown codes pass B
            default: resultLow = bus;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            yReg <= '0;
            zHigh <= '0;
            zLow <= '0;
        end else begin
            if (control.yIn) begin
                yReg <= bus;
            end
            if (control.zHighIn) begin
                zHigh <= resultHigh;
            end
            if (control.zLowIn) begin
                zLow <= resultLow;
            end
        end
    end

endmodule

//--- design/branchCondition.sv
// branch condition decode and the CON flip-flop
`timescale 1ns/10ps

module branchCondition (
    input  logic                                clock,
    input  logic                                arstN,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  bus,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  ir,
    input  datapathPkg::controlWord             control,
    output logic                                con
);
    import datapathPkg::*;

    condCode_t condCode;
    logic      isZero;
    logic      isNegative;
    logic      conditionMet;

    assign condCode = condCode_t'(ir[RB_LSB +: COND_WIDTH]);
    assign isZero = (bus == '0);
    assign isNegative = bus[WORD_WIDTH-1];

    always_comb begin
        case (condCode)
            brzr:    conditionMet = isZero;
            brnz:    conditionMet = !isZero;
            // positive means sign bit clear
            brpl:    conditionMet = !isNegative;
            brmi:    conditionMet = isNegative;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            con <= 1'b0;
        end else if (control.conIn) begin
            con <= conditionMet;
        end
    end

endmodule

//--- design/memoryInterface.sv
// memory address and data registers with the external memory strobes
`timescale 1ns/10ps

module memoryInterface #(
    parameter int addressWidth = 9
) (
    input  logic                                clock,
    input  logic                                arstN,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  bus,
    input  datapathPkg::controlWord             control,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  memData,
    output logic [datapathPkg::WORD_WIDTH-1:0]  mdr,
    output logic [addressWidth-1:0]             memAddress,
    output logic [datapathPkg::WORD_WIDTH-1:0]  memWriteData,
    output logic                                memRead,
    output logic                                memWrite
);
    import datapathPkg::*;

    logic [addressWidth-1:0] mar;
    logic [WORD_WIDTH-1:0]   mdrNext;

    // memory data wins over the bus during a read
    assign mdrNext = control.read ? memData : bus;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (control.marIn) begin
                mar <= bus[addressWidth-1:0];
            end
            if (control.mdrIn) begin
                mdr <= mdrNext;
            end
        end
    end

    assign memAddress = mar;
    assign memWriteData = mdr;
    // strobes go straight out in the same step
    assign memRead = control.read;
    assign memWrite = control.write;

endmodule

//--- design/busMultiplexer.sv
// shared bus source select driven by the out strobes of the control word
`timescale 1ns/10ps

module busMultiplexer (
    input  datapathPkg::controlWord             control,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  pc,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  ir,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  hi,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  lo,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  zHigh,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  zLow,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  mdr,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  regData,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  inPortValue,
    output logic [datapathPkg::WORD_WIDTH-1:0]  bus
);
    import datapathPkg::*;

    logic [WORD_WIDTH-1:0] cValue;

    // sign extended constant field
    assign cValue = {{(WORD_WIDTH-CONST_WIDTH){ir[CONST_WIDTH-1]}}, ir[CONST_WIDTH-1:0]};

    // and-or select, zero when no source drives
    always_comb begin
        bus = '0;
        bus |= {WORD_WIDTH{control.pcOut}} & pc;
        bus |= {WORD_WIDTH{control.zHighOut}} & zHigh;
        bus |= {WORD_WIDTH{control.zLowOut}} & zLow;
        bus |= {WORD_WIDTH{control.mdrOut}} & mdr;
        bus |= {WORD_WIDTH{control.hiOut}} & hi;
        bus |= {WORD_WIDTH{control.loOut}} & lo;
        bus |= {WORD_WIDTH{control.inPortOut}} & inPortValue;
        bus |= {WORD_WIDTH{control.cOut}} & cValue;
        // base address read also uses the register path
        bus |= {WORD_WIDTH{control.rOut || control.baOut}} & regData;
    end

endmodule

//--- design/dataPath.sv
// datapath top level joining registers, ALU, branch logic and memory on one bus
`timescale 1ns/10ps

module dataPath #(
    parameter int addressWidth = 9
) (
    input  logic                                clock,
    input  logic                                arstN,
    input  datapathPkg::controlWord             control,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  inPortData,
    input  logic [datapathPkg::WORD_WIDTH-1:0]  memData,
    output logic [datapathPkg::WORD_WIDTH-1:0]  outPortData,
    output logic [addressWidth-1:0]             memAddress,
    output logic [datapathPkg::WORD_WIDTH-1:0]  memWriteData,
    output logic                                memRead,
    output logic                                memWrite
);
    import datapathPkg::*;

    logic [WORD_WIDTH-1:0] bus;
    logic [WORD_WIDTH-1:0] pc;
    logic [WORD_WIDTH-1:0] ir;
    logic [WORD_WIDTH-1:0] hi;
    logic [WORD_WIDTH-1:0] lo;
    logic [WORD_WIDTH-1:0] zHigh;
    logic [WORD_WIDTH-1:0] zLow;
    logic [WORD_WIDTH-1:0] mdr;
    logic [WORD_WIDTH-1:0] regData;
    logic [WORD_WIDTH-1:0] inPortValue;
    logic                  con;

    busMultiplexer i_busMultiplexer (
        .control     (control),
        .pc          (pc),
        .ir          (ir),
        .hi          (hi),
        .lo          (lo),
        .zHigh       (zHigh),
        .zLow        (zLow),
        .mdr         (mdr),
        .regData     (regData),
        .inPortValue (inPortValue),
        .bus         (bus)
    );

    registerFile i_registerFile (
        .clock   (clock),
        .arstN   (arstN),
        .bus     (bus),
        .ir      (ir),
        .control (control),
        .regData (regData)
    );

    specialRegisters i_specialRegisters (
        .clock       (clock),
        .arstN       (arstN),
        .bus         (bus),
        .control     (control),
        .con         (con),
        .inPortData  (inPortData),
        .pc          (pc),
        .ir          (ir),
        .hi          (hi),
        .lo          (lo),
        .inPortValue (inPortValue),
        .outPortData (outPortData)
    );

    aluUnit i_aluUnit (
        .clock   (clock),
        .arstN   (arstN),
        .bus     (bus),
        .control (control),
        .zHigh   (zHigh),
        .zLow    (zLow)
    );

    branchCondition i_branchCondition (
        .clock   (clock),
        .arstN   (arstN),
        .bus     (bus),
        .ir      (ir),
        .control (control),
        .con     (con)
    );

    memoryInterface #(
        .addressWidth (addressWidth)
    ) i_memoryInterface (
        .clock        (clock),
        .arstN        (arstN),
        .bus          (bus),
        .control      (control),
        .memData      (memData),
        .mdr          (mdr),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memRead      (memRead),
        .memWrite     (memWrite)
    );

endmodule

//--- test/dataPathTb.sv
// testbench running fetch, branch, ALU and store sequences on the bus datapath
`timescale 1ns/10ps

module dataPathTb;
    import datapathPkg::*;

    localparam int PATTERN_COUNT = 8;

    logic clock = 1'b0;
    logic arstN;
    controlWord control;
    logic [31:0] inPortData;
    logic [31:0] memData;
    logic [31:0] outPortData;
    logic [8:0] memAddress;
    logic [31:0] memWriteData;
    logic memRead;
    logic memWrite;
    logic [31:0] mem [0:511];
    logic [31:0] patternWords [0:4*PATTERN_COUNT-1];
    logic [31:0] rngState = 32'h380c;

    dataPath #(.addressWidth(9)) i_dataPath (.*);

    always #50 clock = ~clock;

    // combinational read and clocked write
    assign memData = mem[memAddress];
    always @(posedge clock) begin
        if (memWrite) begin
            mem[memAddress] <= memWriteData;
        end
    end

    initial begin
        for (int c = 0; c < 20000; c++) begin
            @(posedge clock);
        end
        $display("timeout, the run did not reach its end");
        $display("Finished with errors");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // ALU rules with Y as A and the bus as B
    function automatic logic [31:0] aluModel(input int op, input logic [31:0] a, b);
        case (op)
            3: return a + b;
            4: return a - b;
            5: return a & b;
            6: return a | b;
            7: return 32'd0 - b;
            8: return ~b;
            9: return a << b[4:0];
            10: return a >> b[4:0];
            default: return b;
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [31:0] actual, expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %b expected %b", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // hold one control word for one clock
    task automatic runStep(input controlWord cw);
        control = cw;
        @(posedge clock);
        #5;
    endtask

    task automatic loadFromInPort(input logic [31:0] value, input controlWord sink);
        inPortData = value;
        runStep('0);
        sink.inPortOut = 1'b1;
        runStep(sink);
    endtask

    task automatic showOnOutPort(input controlWord source);
        source.outPortIn = 1'b1;
        runStep(source);
    endtask

    task automatic runBranch(input logic [31:0] startPc, instr, raValue, fileExpected);
        controlWord cw;
        logic [31:0] cValue;
        logic taken;
        logic [31:0] expectedPc;
        cValue = {{13{instr[18]}}, instr[18:0]};
        case (instr[20:19])
            2'd0: taken = (raValue == 0);
            2'd1: taken = (raValue != 0);
            2'd2: taken = !raValue[31];
            default: taken = raValue[31];
        endcase
        expectedPc = taken ? startPc + 1 + cValue : startPc + 1;
        if (expectedPc !== fileExpected) begin
            $display("pattern file gives PC %h where the branch rule gives %h",
                     fileExpected, expectedPc);
            $display("Finished with errors");
            $fatal(1);
        end
        mem[startPc[8:0]] <= instr;
        cw = '0;
        cw.pcIn = 1'b1;
        loadFromInPort(startPc, cw);
        // T0
        cw = '0;
        cw.pcOut = 1'b1;
        cw.marIn = 1'b1;
        cw.incPc = 1'b1;
        cw.zLowIn = 1'b1;
        runStep(cw);
        checkWord("memAddress", {23'd0, memAddress}, startPc & 32'h1ff);
        // T1 with the read strobe checked before its edge
        cw = '0;
        cw.zLowOut = 1'b1;
        cw.pcIn = 1'b1;
        cw.read = 1'b1;
        cw.mdrIn = 1'b1;
        control = cw;
        #1 checkFlag("memRead", memRead, 1'b1);
        runStep(cw);
        cw = '0;
        cw.mdrOut = 1'b1;
        cw.irIn = 1'b1;
        runStep(cw);
        cw = '0;
        cw.mdrOut = 1'b1;
        showOnOutPort(cw);
        checkWord("outPortData", outPortData, instr);
        cw = '0;
        cw.gra = 1'b1;
        cw.rIn = 1'b1;
        loadFromInPort(raValue, cw);
        // T3 to T6
        cw = '0;
        cw.gra = 1'b1;
        cw.rOut = 1'b1;
        cw.conIn = 1'b1;
        runStep(cw);
        cw = '0;
        cw.pcOut = 1'b1;
        cw.yIn = 1'b1;
        runStep(cw);
        cw = '0;
        cw.cOut = 1'b1;
        cw.aluOp = aluAdd;
        cw.zLowIn = 1'b1;
        runStep(cw);
        cw = '0;
        cw.zLowOut = 1'b1;
        cw.branchLoad = 1'b1;
        runStep(cw);
        cw = '0;
        cw.pcOut = 1'b1;
        showOnOutPort(cw);
        checkWord("outPortData", outPortData, expectedPc);
    endtask

    task automatic runAluChecks(input logic [31:0] a, b);
        controlWord cw;
        cw = '0;
        cw.yIn = 1'b1;
        loadFromInPort(a, cw);
        // no Gr select writes R0
        cw = '0;
        cw.rIn = 1'b1;
        loadFromInPort(b, cw);
        for (int op = 0; op <= 10; op++) begin
            cw = '0;
            cw.rOut = 1'b1;
            cw.aluOp = aluOp_t'(op);
            cw.zLowIn = 1'b1;
            runStep(cw);
            cw = '0;
            cw.zLowOut = 1'b1;
            showOnOutPort(cw);
            checkWord("outPortData", outPortData, aluModel(op, a, b));
        end
    endtask

    task automatic runStore(input logic [8:0] address, input logic [31:0] value);
        controlWord cw;
        cw = '0;
        cw.marIn = 1'b1;
        loadFromInPort({23'd0, address}, cw);
        cw = '0;
        cw.mdrIn = 1'b1;
        loadFromInPort(value, cw);
        cw = '0;
        cw.write = 1'b1;
        control = cw;
        #1 checkFlag("memWrite", memWrite, 1'b1);
        checkWord("memWriteData", memWriteData, value);
        checkWord("memAddress", {23'd0, memAddress}, {23'd0, address});
        runStep(cw);
        runStep('0);
        checkWord("mem", mem[address], value);
    endtask

    initial begin
        arstN = 1'b0;
        control = '0;
        inPortData = '0;
        for (int a = 0; a < 512; a++) begin
            mem[a] <= 32'h5a000000 ^ (a * 32'h00010001);
        end
        $readmemh("test/branchPatterns.txt", patternWords);
        repeat (2) @(posedge clock);
        #5 arstN = 1'b1;
        checkWord("outPortData", outPortData, 32'd0);
        checkFlag("memRead", memRead, 1'b0);
        checkFlag("memWrite", memWrite, 1'b0);
        for (int p = 0; p < PATTERN_COUNT; p++) begin
            runBranch(patternWords[4*p], patternWords[4*p+1], patternWords[4*p+2],
                      patternWords[4*p+3]);
        end
        for (int n = 0; n < 3; n++) begin
            rngState = xorshift(rngState);
            inPortData = rngState;
            rngState = xorshift(rngState);
            runAluChecks(inPortData, rngState);
        end
        runStore(9'h1a5, 32'hcafe1234);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- branchDatapath.f
design/datapathPkg.sv
design/registerFile.sv
design/specialRegisters.sv
design/aluUnit.sv
design/branchCondition.sv
design/memoryInterface.sv
design/busMultiplexer.sv
design/dataPath.sv
test/dataPathTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -f branchDatapath.f --top-module dataPathTb -o dataPathSim

# the simulator exits nonzero on a failed check, the log decides the result
./obj_dir/dataPathSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

//--- test/branchPatterns.txt
// start PC, instruction word, Ra value, expected final PC
// instruction: opcode 31..27, Ra 26..23, condition 20..19, constant 18..0
00000010 91000010 00000000 00000021
00000020 91000010 00000005 00000021
00000030 91080010 00000007 00000041
00000040 91080010 00000000 00000041
00000050 9297fff8 00000003 00000049
00000060 9117fff8 80000000 00000061
00000070 91180010 ffffffff 00000081
00000080 91180010 12345678 00000081
